// File: compile.f
eye_pkg.sv
camera_input.sv
pixel_binarize.sv
centroid_accumulate.sv
result_fifo.sv
result_serializer.sv
centroid_top.sv
centroid_assert.sv
centroid_tb.sv

// File: Bender.yml
package:
  name: eye_centroid

sources:
  - files:
      - eye_pkg.sv
      - camera_input.sv
      - pixel_binarize.sv
      - centroid_accumulate.sv
      - result_fifo.sv
      - result_serializer.sv
      - centroid_top.sv
  - target: test
    files:
      - centroid_assert.sv
      - centroid_tb.sv

// File: centroid_tb.sv
// Centroid path testbench
`default_nettype none

module centroid_tb import eye_pkg::*; ();

    localparam int MODE_RAND    = 0;
    localparam int MODE_ZERO    = 1;
    localparam int MODE_FULL    = 2;
    localparam int NUM_FRAMES   = 15;
    localparam int MAX_PIX      = 256;
    localparam int CREDIT_DELAY = 2;

    typedef struct {
        int w;
        int h;
        int thr;
        int mode;
        int hold;
        int gap;
        bit last;
    } frame_cfg_t;

    logic        cclk;
    logic        rst;
    logic        fval;
    logic        lval;
    logic        dval;
    pixel_t      data_l;
    pixel_t      data_r;
    pixel_t      threshold;
    logic        tx_credit;
    logic        tx_valid;
    byte_t       tx_data;
    drop_count_t drop_count;

    frame_cfg_t  tbl [NUM_FRAMES];
    pixel_t      pix_mem [MAX_PIX];
    byte_t       exp_q [$];
    int          credit_due [$];
    integer      seed;
    int          cycle;
    int          cycle_limit;
    int          errors;
    int          checks;
    int          rx_count;
    int          hold_base;
    int          held;
    drop_count_t exp_drop;
    bit          withhold;

    centroid_top i_centroid_top (
        .cclk       (cclk),
        .rst        (rst),
        .fval       (fval),
        .lval       (lval),
        .dval       (dval),
        .data_l     (data_l),
        .data_r     (data_r),
        .threshold  (threshold),
        .tx_credit  (tx_credit),
        .tx_valid   (tx_valid),
        .tx_data    (tx_data),
        .drop_count (drop_count)
    );

    always #4 cclk = ~cclk;

    // Run length limit
    always @(posedge cclk) begin
        cycle = cycle + 1;
        if (cycle > cycle_limit) begin
            $display("Timeout after %0d cycles, %0d expected bytes never arrived",
                     cycle_limit, exp_q.size());
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // --------------------
    // Checks
    // --------------------
    task automatic check_byte(input byte_t got, input byte_t exp, input int idx);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t: record byte %0d is 8'h%02h, expected 8'h%02h",
                     $time, idx, got, exp);
            errors++;
        end
    endtask

    task automatic check_drop(input drop_count_t got, input drop_count_t exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t: drop_count is %0d, expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    // Byte monitor and receiver credit model
    always @(negedge cclk) begin
        tx_credit = 1'b0;
        if (tx_valid) begin
            rx_count++;
            credit_due.push_back(cycle + CREDIT_DELAY);
            if (credit_due.size() > TX_CREDITS) begin
                $display("[ERROR] %0t: %0d bytes outstanding, receiver grants only %0d",
                         $time, credit_due.size(), TX_CREDITS);
                errors++;
            end
            if (exp_q.size() == 0) begin
                $display("[ERROR] %0t: unexpected byte 8'h%02h with no record pending",
                         $time, tx_data);
                errors++;
            end else begin
                check_byte(tx_data, exp_q.pop_front(), (rx_count - 1) % RECORD_BYTES);
            end
        end
        if (!withhold && credit_due.size() != 0) begin
            if (credit_due[0] <= cycle) begin
                void'(credit_due.pop_front());
                tx_credit = 1'b1;
            end
        end
    end

    // --------------------
    // Stimulus table
    // --------------------
    task automatic load_table();
        // w, h, threshold, mode, hold, gap, last frame of test
        tbl[0]  = '{16, 6, 128, MODE_RAND, 0, 8, 1'b1};
        tbl[1]  = '{8, 4, 0, MODE_ZERO, 0, 8, 1'b1};
        tbl[2]  = '{8, 4, 0, MODE_FULL, 0, 8, 1'b1};
        tbl[3]  = '{16, 6, 100, MODE_RAND, 40, 8, 1'b1};
        // Back-to-back frames with a new threshold each
        tbl[4]  = '{8, 4, 50, MODE_RAND, 0, 4, 1'b0};
        tbl[5]  = '{8, 4, 100, MODE_RAND, 0, 4, 1'b0};
        tbl[6]  = '{8, 4, 150, MODE_RAND, 0, 4, 1'b0};
        tbl[7]  = '{8, 4, 200, MODE_RAND, 0, 4, 1'b1};
        // Seven frames with the receiver stalled
        tbl[8]  = '{6, 2, 128, MODE_RAND, 60, 4, 1'b0};
        tbl[9]  = '{6, 2, 128, MODE_RAND, 60, 4, 1'b0};
        tbl[10] = '{6, 2, 128, MODE_RAND, 60, 4, 1'b0};
        tbl[11] = '{6, 2, 128, MODE_RAND, 60, 4, 1'b0};
        tbl[12] = '{6, 2, 128, MODE_RAND, 60, 4, 1'b0};
        tbl[13] = '{6, 2, 128, MODE_RAND, 60, 4, 1'b0};
        tbl[14] = '{6, 2, 128, MODE_RAND, 60, 4, 1'b1};
    endtask

    task automatic push_record(input int s, input int sx, input int sy);
        int k;
        exp_q.push_back(RECORD_HEADER);
        for (k = 2; k >= 0; k--) begin
            exp_q.push_back(byte_t'(s >> (8 * k)));
        end
        for (k = 3; k >= 0; k--) begin
            exp_q.push_back(byte_t'(sx >> (8 * k)));
        end
        for (k = 3; k >= 0; k--) begin
            exp_q.push_back(byte_t'(sy >> (8 * k)));
        end
    endtask

    // Fill pixels and form the expected record
    task automatic make_frame(input int i);
        int x;
        int y;
        int idx;
        int s;
        int sx;
        int sy;
        s = 0;
        sx = 0;
        sy = 0;
        for (y = 0; y < tbl[i].h; y++) begin
            for (x = 0; x < tbl[i].w; x++) begin
                idx = y * tbl[i].w + x;
                case (tbl[i].mode)
                    MODE_ZERO: pix_mem[idx] = 8'h00;
                    MODE_FULL: pix_mem[idx] = 8'hff;
                    default:   pix_mem[idx] = pixel_t'($random(seed));
                endcase
                if (int'(pix_mem[idx]) > tbl[i].thr) begin
                    s += 1;
                    sx += x;
                    sy += y;
                end
            end
        end
        // One record in the serializer plus a full FIFO
        if (withhold && held >= FIFO_DEPTH + 1) begin
            exp_drop++;
        end else begin
            push_record(s, sx, sy);
        end
        if (withhold) begin
            held++;
        end
    endtask

    task automatic drive_frame(input int i);
        int x;
        int y;
        @(negedge cclk);
        threshold = pixel_t'(tbl[i].thr);
        fval = 1'b1;
        for (y = 0; y < tbl[i].h; y++) begin
            for (x = 0; x < tbl[i].w; x += 2) begin
                @(negedge cclk);
                lval = 1'b1;
                dval = 1'b0;
                data_l = pix_mem[y * tbl[i].w + x];
                data_r = pix_mem[y * tbl[i].w + x + 1];
            end
            @(negedge cclk);
            lval = 1'b0;
            dval = 1'b1;
        end
        @(negedge cclk);
        fval = 1'b0;
        repeat (tbl[i].gap - 1) @(negedge cclk);
    endtask

    task automatic wait_drain();
        do begin
            @(posedge cclk);
        end while (exp_q.size() != 0 || credit_due.size() != 0);
        repeat (4) @(posedge cclk);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        int i;
        int first;
        int test_num;
        int err_base;
        int rx_base;
        int assert_fails;
        cclk = 1'b0;
        rst = 1'b1;
        fval = 1'b0;
        lval = 1'b0;
        dval = 1'b1;
        data_l = '0;
        data_r = '0;
        threshold = '0;
        tx_credit = 1'b0;
        seed = 32'hacc4;
        cycle = 0;
        errors = 0;
        checks = 0;
        rx_count = 0;
        held = 0;
        hold_base = 0;
        exp_drop = '0;
        withhold = 1'b0;
        load_table();
        cycle_limit = 200;
        for (i = 0; i < NUM_FRAMES; i++) begin
            cycle_limit += 12 + tbl[i].h * (tbl[i].w / 2 + 1) + tbl[i].gap + tbl[i].hold;
            cycle_limit += RECORD_BYTES * (CREDIT_DELAY + 2);
        end

        repeat (10) @(negedge cclk);
        rst = 1'b0;

        // Idle output after reset
        repeat (30) @(posedge cclk);
        @(negedge cclk);
        check_drop(drop_count, '0);
        $display("Test 0 idle after reset: %0d bytes received, %0d errors", rx_count, errors);

        test_num = 0;
        first = 0;
        err_base = errors;
        rx_base = rx_count;
        for (i = 0; i < NUM_FRAMES; i++) begin
            @(posedge cclk);
            if (tbl[i].hold > 0 && !withhold) begin
                withhold = 1'b1;
                hold_base = rx_count;
                held = 0;
            end
            make_frame(i);
            drive_frame(i);
            if (tbl[i].last) begin
                if (tbl[i].hold > 0) begin
                    repeat (tbl[i].hold) @(posedge cclk);
                    checks++;
                    if (rx_count - hold_base != TX_CREDITS) begin
                        $display("[ERROR] %0t: %0d bytes sent while withheld, expected %0d",
                                 $time, rx_count - hold_base, TX_CREDITS);
                        errors++;
                    end
                    withhold = 1'b0;
                end
                wait_drain();
                @(negedge cclk);
                check_drop(drop_count, exp_drop);
                test_num++;
                $display("Test %0d frames %0d-%0d: %0d bytes received, %0d errors",
                         test_num, first, i, rx_count - rx_base, errors - err_base);
                first = i + 1;
                err_base = errors;
                rx_base = rx_count;
            end
        end

        repeat (20) @(posedge cclk);
        if (exp_q.size() != 0) begin
            $display("Records missing: %0d expected bytes never arrived", exp_q.size());
            errors++;
        end
        assert_fails = i_centroid_top.i_centroid_assert.fail_count;
        if (assert_fails != 0) begin
            $display("Protocol assertions failed %0d times", assert_fails);
            errors += assert_fails;
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", test_num + 1, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: centroid_assert.sv
// Credit protocol assertions
`default_nettype none

module centroid_assert import eye_pkg::*; (
    input logic                            cclk,
    input logic                            rst,
    input logic                            tx_valid,
    input logic                            tx_credit,
    input logic [$clog2(TX_CREDITS+1)-1:0] credits
);

    int fail_count = 0;
    int open_bytes;

    // Bytes on the link the receiver has not credited back yet
    always @(posedge cclk) begin
        if (rst) begin
            open_bytes <= 0;
        end else begin
            open_bytes <= open_bytes + int'(tx_valid) - int'(tx_credit);
        end
    end

    // --------------------
    // Credit handshake
    // --------------------
    no_send_without_credit: assert property (
        @(posedge cclk) disable iff (rst) tx_valid |-> open_bytes < TX_CREDITS
    ) else begin
        $error("tx_valid high with every receiver credit in use");
        fail_count++;
    end

    credit_bound: assert property (
        @(posedge cclk) disable iff (rst)
            credits <= TX_CREDITS && int'(credits) + open_bytes == TX_CREDITS
    ) else begin
        $error("credit count above the grant or out of step with the link");
        fail_count++;
    end

    // Registers settle after the first reset edge
    quiet_in_reset: assert property (
        @(posedge cclk) rst && $past(rst) |-> !tx_valid
    ) else begin
        $error("tx_valid high during reset");
        fail_count++;
    end

endmodule

bind centroid_top centroid_assert i_centroid_assert (
    .cclk      (cclk),
    .rst       (rst),
    .tx_valid  (tx_valid),
    .tx_credit (tx_credit),
    .credits   (i_result_serializer.credits)
);

`default_nettype wire

// File: centroid_top.sv
// Eye tracker centroid path
`default_nettype none

module centroid_top import eye_pkg::*; (
    input  logic        cclk,
    input  logic        rst,
    input  logic        fval,
    input  logic        lval,
    input  logic        dval,
    input  pixel_t      data_l,
    input  pixel_t      data_r,
    input  pixel_t      threshold,
    input  logic        tx_credit,
    output logic        tx_valid,
    output byte_t       tx_data,
    output drop_count_t drop_count
);

    // Camera stage
    logic   pix_valid;
    pixel_t pix_l;
    pixel_t pix_r;
    pos_t   pos_x;
    pos_t   pos_y;
    logic   frame_end;

    // Binarized contributions
    logic        contrib_valid;
    logic [1:0]  contrib_count;
    logic [10:0] contrib_x;
    logic [10:0] contrib_y;
    logic        frame_done;

    // Result queue
    logic      push;
    logic      pop;
    logic      empty;
    logic      full;
    centroid_t result;
    centroid_t head;

    camera_input i_camera_input (
        .cclk      (cclk),
        .rst       (rst),
        .fval      (fval),
        .lval      (lval),
        .dval      (dval),
        .data_l    (data_l),
        .data_r    (data_r),
        .pix_valid (pix_valid),
        .pix_l     (pix_l),
        .pix_r     (pix_r),
        .pos_x     (pos_x),
        .pos_y     (pos_y),
        .frame_end (frame_end)
    );

    pixel_binarize i_pixel_binarize (
        .cclk          (cclk),
        .rst           (rst),
        .threshold     (threshold),
        .pix_valid     (pix_valid),
        .pix_l         (pix_l),
        .pix_r         (pix_r),
        .pos_x         (pos_x),
        .pos_y         (pos_y),
        .frame_end     (frame_end),
        .contrib_valid (contrib_valid),
        .contrib_count (contrib_count),
        .contrib_x     (contrib_x),
        .contrib_y     (contrib_y),
        .frame_done    (frame_done)
    );

    centroid_accumulate i_centroid_accumulate (
        .cclk          (cclk),
        .rst           (rst),
        .contrib_valid (contrib_valid),
        .contrib_count (contrib_count),
        .contrib_x     (contrib_x),
        .contrib_y     (contrib_y),
        .frame_done    (frame_done),
        .full          (full),
        .push          (push),
        .result        (result),
        .drop_count    (drop_count)
    );

    result_fifo i_result_fifo (
        .cclk    (cclk),
        .rst     (rst),
        .push    (push),
        .data_in (result),
        .pop     (pop),
        .head    (head),
        .empty   (empty),
        .full    (full)
    );

    result_serializer i_result_serializer (
        .cclk      (cclk),
        .rst       (rst),
        .empty     (empty),
        .head      (head),
        .tx_credit (tx_credit),
        .pop       (pop),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data)
    );

endmodule

`default_nettype wire

// File: result_serializer.sv
// Result record byte serializer
`default_nettype none

module result_serializer import eye_pkg::*; (
    input  logic      cclk,
    input  logic      rst,
    input  logic      empty,
    input  centroid_t head,
    input  logic      tx_credit,
    output logic      pop,
    output logic      tx_valid,
    output byte_t     tx_data
);

    typedef logic [$clog2(TX_CREDITS+1)-1:0] credit_t;
    typedef logic [$clog2(RECORD_BYTES)-1:0] idx_t;

    logic                      busy;
    idx_t                      byte_idx;
    credit_t                   credits;
    logic [RECORD_BYTES*8-1:0] shreg;

    // Take a new result only when the previous record is out
    assign pop = !busy && !empty;

    // One byte per cycle while a credit is held
    assign tx_valid = busy && (credits != '0);
    assign tx_data  = shreg[RECORD_BYTES*8-1 -: 8];

    // --------------------
    // Record sequencing
    // --------------------
    always_ff @(posedge cclk) begin
        if (rst) begin
            busy     <= 1'b0;
            byte_idx <= '0;
        end else if (pop) begin
            busy     <= 1'b1;
            byte_idx <= '0;
        end else if (tx_valid) begin
            if (byte_idx == idx_t'(RECORD_BYTES - 1)) begin
                busy     <= 1'b0;
                byte_idx <= '0;
            end else begin
                byte_idx <= byte_idx + idx_t'(1);
            end
        end
    end

    // --------------------
    // Credit counter
    // --------------------
    always_ff @(posedge cclk) begin
        if (rst) begin
            credits <= credit_t'(TX_CREDITS);
        end else begin
            case ({tx_valid, tx_credit})
                2'b10: credits <= credits - credit_t'(1);
                2'b01: begin
                    if (credits != credit_t'(TX_CREDITS)) begin
                        credits <= credits + credit_t'(1);
                    end
                end
                default: credits <= credits;
            endcase
        end
    end

    // Header, then S, SX, SY zero-extended, MSB first
    always_ff @(posedge cclk) begin
        if (pop) begin
            shreg <= {RECORD_HEADER, 24'(head.s), 32'(head.sx), 32'(head.sy)};
        end else if (tx_valid) begin
            shreg <= {shreg[RECORD_BYTES*8-9:0], 8'h00};
        end
    end

endmodule

`default_nettype wire

// File: result_fifo.sv
// Frame result queue
`default_nettype none

module result_fifo import eye_pkg::*; (
    input  logic      cclk,
    input  logic      rst,
    input  logic      push,
    input  centroid_t data_in,
    input  logic      pop,
    output centroid_t head,
    output logic      empty,
    output logic      full
);

    typedef logic [$clog2(FIFO_DEPTH)-1:0]   ptr_t;
    typedef logic [$clog2(FIFO_DEPTH+1)-1:0] cnt_t;

    centroid_t mem [FIFO_DEPTH];
    ptr_t      wr_ptr;
    ptr_t      rd_ptr;
    cnt_t      count;
    logic      do_push;
    logic      do_pop;

    function automatic ptr_t next_ptr(input ptr_t p);
        return (p == ptr_t'(FIFO_DEPTH - 1)) ? '0 : p + ptr_t'(1);
    endfunction

    assign full    = count == cnt_t'(FIFO_DEPTH);
    assign empty   = count == '0;
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Oldest entry always visible
    assign head = mem[rd_ptr];

    always_ff @(posedge cclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + cnt_t'(1);
                2'b01:   count <= count - cnt_t'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge cclk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

endmodule

`default_nettype wire

// File: centroid_accumulate.sv
// Per-frame centroid sums
`default_nettype none

module centroid_accumulate import eye_pkg::*; (
    input  logic        cclk,
    input  logic        rst,
    input  logic        contrib_valid,
    input  logic [1:0]  contrib_count,
    input  logic [10:0] contrib_x,
    input  logic [10:0] contrib_y,
    input  logic        frame_done,
    input  logic        full,
    output logic        push,
    output centroid_t   result,
    output drop_count_t drop_count
);

    sum_s_t  acc_s;
    sum_sx_t acc_sx;
    sum_sy_t acc_sy;

    // --------------------
    // Accumulators and push
    // --------------------
    always_ff @(posedge cclk) begin
        if (rst) begin
            acc_s      <= '0;
            acc_sx     <= '0;
            acc_sy     <= '0;
            push       <= 1'b0;
            drop_count <= '0;
        end else begin
            push <= 1'b0;
            if (frame_done) begin
                // Start the next frame from zero
                acc_s  <= '0;
                acc_sx <= '0;
                acc_sy <= '0;
                if (full) begin
                    // Result is lost, count it
                    if (drop_count != '1) begin
                        drop_count <= drop_count + drop_count_t'(1);
                    end
                end else begin
                    push <= 1'b1;
                end
            end else if (contrib_valid) begin
                acc_s  <= acc_s + sum_s_t'(contrib_count);
                acc_sx <= acc_sx + sum_sx_t'(contrib_x);
                acc_sy <= acc_sy + sum_sy_t'(contrib_y);
            end
        end
    end

    // --------------------
    // Result capture
    // --------------------
    always_ff @(posedge cclk) begin
        if (frame_done) begin
            result.s  <= acc_s;
            result.sx <= acc_sx;
            result.sy <= acc_sy;
        end
    end

endmodule

`default_nettype wire

// File: pixel_binarize.sv
// Pixel pair thresholding
`default_nettype none

module pixel_binarize import eye_pkg::*; (
    input  logic        cclk,
    input  logic        rst,
    input  pixel_t      threshold,
    input  logic        pix_valid,
    input  pixel_t      pix_l,
    input  pixel_t      pix_r,
    input  pos_t        pos_x,
    input  pos_t        pos_y,
    input  logic        frame_end,
    output logic        contrib_valid,
    output logic [1:0]  contrib_count,
    output logic [10:0] contrib_x,
    output logic [10:0] contrib_y,
    output logic        frame_done
);

    pixel_t      thr_q;
    logic        in_frame;
    logic        hit_l;
    logic        hit_r;
    logic [10:0] x_l;
    logic [10:0] x_r;

    // Set pixel when strictly above threshold
    assign hit_l = pix_l > thr_q;
    assign hit_r = pix_r > thr_q;

    // Left pixel at x, right pixel at x+1
    assign x_l = hit_l ? {1'b0, pos_x} : '0;
    assign x_r = hit_r ? {1'b0, pos_x} + 11'd1 : '0;

    always_ff @(posedge cclk) begin
        if (rst) begin
            thr_q         <= '0;
            in_frame      <= 1'b0;
            contrib_valid <= 1'b0;
            frame_done    <= 1'b0;
        end else begin
            contrib_valid <= pix_valid;
            frame_done    <= frame_end;
            if (frame_end) begin
                in_frame <= 1'b0;
            end else if (pix_valid) begin
                in_frame <= 1'b1;
            end
            // Threshold only follows the input between frames
            if (!in_frame && !pix_valid) begin
                thr_q <= threshold;
            end
        end
    end

    always_ff @(posedge cclk) begin
        contrib_count <= {1'b0, hit_l} + {1'b0, hit_r};
        contrib_x     <= x_l + x_r;
        // y times number of set pixels
        if (hit_l && hit_r) begin
            contrib_y <= {pos_y, 1'b0};
        end else if (hit_l || hit_r) begin
            contrib_y <= {1'b0, pos_y};
        end else begin
            contrib_y <= '0;
        end
    end

endmodule

`default_nettype wire

// File: camera_input.sv
// Camera sync cleanup and position counting
`default_nettype none

module camera_input import eye_pkg::*; (
    input  logic   cclk,
    input  logic   rst,
    input  logic   fval,
    input  logic   lval,
    input  logic   dval,
    input  pixel_t data_l,
    input  pixel_t data_r,
    output logic   pix_valid,
    output pixel_t pix_l,
    output pixel_t pix_r,
    output pos_t   pos_x,
    output pos_t   pos_y,
    output logic   frame_end
);

    logic fval_q;
    logic lval_q;
    logic dval_act;
    logic pair_valid;
    logic line_start;
    logic line_end;
    logic frame_start;
    pos_t x_cnt;
    pos_t y_cnt;
    pos_t x_cur;
    pos_t y_cur;

    // Fixed strobe polarity
    assign dval_act   = DVAL_ACTIVE_LOW ? ~dval : dval;
    assign pair_valid = fval & lval & dval_act;

    // Edges against the previous sample
    assign line_start  = lval & ~lval_q;
    assign line_end    = ~lval & lval_q;
    assign frame_start = fval & ~fval_q;

    // First pair of a line sits at x = 0, first line of a frame at y = 0
    assign x_cur = line_start ? '0 : x_cnt;
    assign y_cur = frame_start ? '0 : y_cnt;

    always_ff @(posedge cclk) begin
        if (rst) begin
            fval_q    <= 1'b0;
            lval_q    <= 1'b0;
            pix_valid <= 1'b0;
            frame_end <= 1'b0;
            x_cnt     <= '0;
            y_cnt     <= '0;
        end else begin
            fval_q    <= fval;
            lval_q    <= lval;
            pix_valid <= pair_valid;
            frame_end <= fval_q & ~fval;
            // Two pixels per clock
            if (pair_valid) begin
                x_cnt <= x_cur + pos_t'(2);
            end else begin
                x_cnt <= x_cur;
            end
            if (frame_start) begin
                y_cnt <= '0;
            end else if (line_end) begin
                y_cnt <= y_cnt + pos_t'(1);
            end
        end
    end

    always_ff @(posedge cclk) begin
        pix_l <= data_l;
        pix_r <= data_r;
        pos_x <= x_cur;
        pos_y <= y_cur;
    end

endmodule

`default_nettype wire

// File: eye_pkg.sv
// Eye tracker shared definitions
`default_nettype none

package eye_pkg;

    // --------------------
    // Pixel stream
    // --------------------
    localparam int PIXEL_WIDTH = 8;
    typedef logic [PIXEL_WIDTH-1:0] pixel_t;

    localparam int POS_WIDTH = 10;
    typedef logic [POS_WIDTH-1:0] pos_t;

    // Camera data-valid strobe is low when a pixel pair is present
    localparam bit DVAL_ACTIVE_LOW = 1'b1;

    // --------------------
    // Centroid sums
    // --------------------
    localparam int SUM_S_WIDTH  = 20;
    localparam int SUM_SX_WIDTH = 28;
    localparam int SUM_SY_WIDTH = 28;

    typedef logic [SUM_S_WIDTH-1:0]  sum_s_t;
    typedef logic [SUM_SX_WIDTH-1:0] sum_sx_t;
    typedef logic [SUM_SY_WIDTH-1:0] sum_sy_t;

    // One frame result, 76 bits
    typedef struct packed {
        sum_s_t  s;
        sum_sx_t sx;
        sum_sy_t sy;
    } centroid_t;

    // --------------------
    // Queue and byte output
    // --------------------
    localparam int FIFO_DEPTH = 4;
    localparam int TX_CREDITS = 4;

    typedef logic [7:0] byte_t;
    typedef logic [7:0] drop_count_t;

    localparam byte_t RECORD_HEADER = 8'hA5;
    localparam int    RECORD_BYTES  = 12;

endpackage

`default_nettype wire
